// ==== list.f ====
source/issue_pkg.sv
source/instr_decoder.sv
source/rename_unit.sv
source/issue_sequencer.sv
source/issue_top.sv
sim/tb_issue_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the issue stage testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot change to the project root"
    exit 1
fi

verilator --binary --timing --top-module tb_issue_top -f list.f -o sim_issue
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_issue
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0

// ==== sim/issue_testdata.txt ====
# req w0 w1 redir_valid redir_lane redir_id redir_pc imem_addr_after (hex)
# then lane 0 and lane 1: valid pc issue_id phy_rs phy_rt phy_dst next_pc alloc_pr
# two addu, second reads the first one's new mapping
3 00430821 00252021 0 0 0 0 3008 1 3000 0 2 3 20 3004 20 1 3004 1 20 5 21 3008 21
# lane 1 alone takes slot 0
2 00243021 00000000 0 0 0 0 300c 0 0 0 0 0 0 0 0 1 3008 2 20 21 22 300c 22
# j in slot 0, slot 1 dropped
3 08001000 00213821 0 0 0 0 4000 1 300c 3 0 0 0 4000 0 0 0 0 0 0 0 0 0
# jr r6, then wait for id 4
3 00c00008 00213821 0 0 0 0 4004 1 4000 4 22 0 0 0 0 0 0 0 0 0 0 0 0
3 00213821 00213821 0 0 0 0 4004 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 00213821 00213821 1 1 3 5000 4004 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 00213821 00213821 1 0 4 5000 5000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# resume, supersede r1 and r4 so 32 and 33 go to the reclaim list
3 00240821 34240010 0 0 0 0 5008 1 5000 5 20 21 23 5004 23 1 5004 6 23 0 24 5008 24
# addu r2,r2,r3 on lane 0 until 37 to 47 are used up
1 00431021 00000000 0 0 0 0 500c 1 5008 7 2 3 25 500c 25 0 0 0 0 0 0 0 0
1 00431021 00000000 0 0 0 0 5010 1 500c 8 25 3 26 5010 26 0 0 0 0 0 0 0 0
1 00431021 00000000 0 0 0 0 5014 1 5010 9 26 3 27 5014 27 0 0 0 0 0 0 0 0
1 00431021 00000000 0 0 0 0 5018 1 5014 a 27 3 28 5018 28 0 0 0 0 0 0 0 0
1 00431021 00000000 0 0 0 0 501c 1 5018 b 28 3 29 501c 29 0 0 0 0 0 0 0 0
1 00431021 00000000 0 0 0 0 5020 1 501c c 29 3 2a 5020 2a 0 0 0 0 0 0 0 0
1 00431021 00000000 0 0 0 0 5024 1 5020 d 2a 3 2b 5024 2b 0 0 0 0 0 0 0 0
1 00431021 00000000 0 0 0 0 5028 1 5024 e 2b 3 2c 5028 2c 0 0 0 0 0 0 0 0
1 00431021 00000000 0 0 0 0 502c 1 5028 f 2c 3 2d 502c 2d 0 0 0 0 0 0 0 0
1 00431021 00000000 0 0 0 0 5030 1 502c 10 2d 3 2e 5030 2e 0 0 0 0 0 0 0 0
1 00431021 00000000 0 0 0 0 5034 1 5030 11 2e 3 2f 5034 2f 0 0 0 0 0 0 0 0
# no free register, stall and hold the pc
1 00431021 00000000 0 0 0 0 5034 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
# both lanes request, reclaim list freed first
3 00431021 00422821 0 0 0 0 503c 1 5034 12 2f 3 20 5038 20 1 5038 13 20 20 21 503c 21
# sw r2,0(r4) has no destination
1 ac820000 00000000 0 0 0 0 5040 1 503c 14 24 20 0 5040 0 0 0 0 0 0 0 0 0
0 00000000 00000000 0 0 0 0 5040 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

// ==== sim/tb_issue_top.sv ====
`timescale 1ns/1ps

module tb_issue_top;

    import issue_pkg::*;

    localparam int half_period  = 20;
    localparam int reset_cycles = 16;
    localparam int max_vec      = 64;
    localparam int num_cols     = 24;

    // column layout of one vector line
    localparam int col_req   = 0;
    localparam int col_w0    = 1;
    localparam int col_w1    = 2;
    localparam int col_rv    = 3;
    localparam int col_rl    = 4;
    localparam int col_rid   = 5;
    localparam int col_rpc   = 6;
    localparam int col_addr  = 7;
    localparam int col_lane  = 8;
    localparam int lane_cols = 8;

    logic        clk;
    logic        rst_n;
    logic        req            [num_lanes];
    logic [31:0] imem_data      [num_lanes];
    logic        redirect_valid [num_lanes];
    issue_id_t   redirect_id    [num_lanes];
    logic [31:0] redirect_pc    [num_lanes];
    logic [31:0] imem_addr;
    logic        pkt_valid      [num_lanes];
    logic [31:0] pkt_pc         [num_lanes];
    issue_id_t   pkt_issue_id   [num_lanes];
    phy_idx_t    pkt_phy_rs     [num_lanes];
    phy_idx_t    pkt_phy_rt     [num_lanes];
    phy_idx_t    pkt_phy_dst    [num_lanes];
    logic [31:0] pkt_next_pc    [num_lanes];
    logic        rf_alloc_wen   [num_lanes];
    phy_idx_t    rf_alloc_pr    [num_lanes];

    logic [31:0] vec    [max_vec][num_cols];
    logic [31:0] fields [num_cols];
    int          num_vec;
    logic        vec_loaded;

    issue_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .imem_data      (imem_data),
        .redirect_valid (redirect_valid),
        .redirect_id    (redirect_id),
        .redirect_pc    (redirect_pc),
        .imem_addr      (imem_addr),
        .pkt_valid      (pkt_valid),
        .pkt_pc         (pkt_pc),
        .pkt_issue_id   (pkt_issue_id),
        .pkt_phy_rs     (pkt_phy_rs),
        .pkt_phy_rt     (pkt_phy_rt),
        .pkt_phy_dst    (pkt_phy_dst),
        .pkt_next_pc    (pkt_next_pc),
        .rf_alloc_wen   (rf_alloc_wen),
        .rf_alloc_pr    (rf_alloc_pr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #half_period clk = ~clk;
        end
    end

    // ========================================================================
    // failure and compare helpers
    // ========================================================================
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "stopped on first error");
    endtask

    function automatic string lane_signal(input string base, input int l);
        return $sformatf("%s[%0d]", base, l);
    endfunction

    task automatic check_pc(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_id(input string name, input issue_id_t exp, input issue_id_t act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH time=%0t %s expected=%h actual=%h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_phy(input string name, input phy_idx_t exp, input phy_idx_t act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH time=%0t %s expected=%0d actual=%0d",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            fail_run($sformatf("MISMATCH time=%0t %s expected=%b actual=%b",
                               $time, name, exp, act));
        end
    endtask

    // ========================================================================
    // vector file, drive and check
    // ========================================================================
    task automatic load_vectors();
        int    fd;
        int    got;
        int    n;
        string line;
        fd = $fopen("sim/issue_testdata.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the vector file sim/issue_testdata.txt");
        end else begin
            num_vec = 0;
            while (!$feof(fd)) begin
                got = $fgets(line, fd);
                // skip comments and blank lines
                if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                fields[0], fields[1], fields[2], fields[3],
                                fields[4], fields[5], fields[6], fields[7],
                                fields[8], fields[9], fields[10], fields[11],
                                fields[12], fields[13], fields[14], fields[15],
                                fields[16], fields[17], fields[18], fields[19],
                                fields[20], fields[21], fields[22], fields[23]);
                    if (n != num_cols) begin
                        fail_run($sformatf("vector line %0d has %0d fields", num_vec, n));
                    end else if (num_vec >= max_vec) begin
                        fail_run("the vector file holds more lines than the testbench can store");
                    end else begin
                        for (int c = 0; c < num_cols; c++) begin
                            vec[num_vec][c] = fields[c];
                        end
                        num_vec++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_vector(input int i, input logic idle);
        for (int l = 0; l < num_lanes; l++) begin
            if (idle) begin
                req[l]            <= 1'b0;
                imem_data[l]      <= '0;
                redirect_valid[l] <= 1'b0;
                redirect_id[l]    <= '0;
                redirect_pc[l]    <= '0;
            end else begin
                req[l]            <= vec[i][col_req][l];
                imem_data[l]      <= vec[i][col_w0 + l];
                // one redirect per line, steered to its lane
                redirect_valid[l] <= vec[i][col_rv][0] && (vec[i][col_rl] == 32'(l));
                redirect_id[l]    <= vec[i][col_rid][id_width-1:0];
                redirect_pc[l]    <= vec[i][col_rpc];
            end
        end
    endtask

    task automatic check_vector(input int i);
        int   base;
        logic exp_wen;
        check_pc("imem_addr", vec[i][col_addr], imem_addr);
        for (int l = 0; l < num_lanes; l++) begin
            base    = col_lane + lane_cols * l;
            exp_wen = vec[i][base][0] && (vec[i][base + 7] != 32'd0);
            check_bit(lane_signal("pkt_valid", l), vec[i][base][0], pkt_valid[l]);
            check_pc(lane_signal("pkt_pc", l), vec[i][base + 1], pkt_pc[l]);
            check_id(lane_signal("pkt_issue_id", l), vec[i][base + 2][id_width-1:0],
                     pkt_issue_id[l]);
            check_phy(lane_signal("pkt_phy_rs", l), vec[i][base + 3][phy_idx_w-1:0],
                      pkt_phy_rs[l]);
            check_phy(lane_signal("pkt_phy_rt", l), vec[i][base + 4][phy_idx_w-1:0],
                      pkt_phy_rt[l]);
            check_phy(lane_signal("pkt_phy_dst", l), vec[i][base + 5][phy_idx_w-1:0],
                      pkt_phy_dst[l]);
            check_pc(lane_signal("pkt_next_pc", l), vec[i][base + 6], pkt_next_pc[l]);
            check_bit(lane_signal("rf_alloc_wen", l), exp_wen, rf_alloc_wen[l]);
            check_phy(lane_signal("rf_alloc_pr", l), vec[i][base + 7][phy_idx_w-1:0],
                      rf_alloc_pr[l]);
        end
    endtask

    // watchdog, one cycle per vector plus slack for reset
    initial begin
        wait (vec_loaded);
        repeat (num_vec + 30) @(posedge clk);
        fail_run("watchdog expired before the vector run finished");
    end

    initial begin
        rst_n      = 1'b0;
        vec_loaded = 1'b0;
        for (int l = 0; l < num_lanes; l++) begin
            req[l]            = 1'b0;
            imem_data[l]      = '0;
            redirect_valid[l] = 1'b0;
            redirect_id[l]    = '0;
            redirect_pc[l]    = '0;
        end
        load_vectors();
        vec_loaded = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_pc("imem_addr", 32'h0000_3000, imem_addr);
        for (int l = 0; l < num_lanes; l++) begin
            check_bit(lane_signal("pkt_valid", l), 1'b0, pkt_valid[l]);
            check_bit(lane_signal("rf_alloc_wen", l), 1'b0, rf_alloc_wen[l]);
        end

        // line i goes in at one edge, its packets show after the next
        for (int i = 0; i <= num_vec; i++) begin
            @(posedge clk);
            apply_vector(i, i == num_vec);
            if (i > 0) begin
                @(negedge clk);
                check_vector(i - 1);
            end
        end

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  issue_pkg::instr_u      instr,
    output issue_pkg::instr_kind_e kind,
    output logic [4:0]             rs,
    output logic [4:0]             rt,
    output logic                   rs_used,
    output logic                   rt_used,
    output logic [4:0]             dest_lr,
    output logic                   has_dest,
    output logic [15:0]            imm16,
    output logic [25:0]            target26
);

    import issue_pkg::*;

    // classify by opcode, then funct for special
    always_comb begin
        kind = other;
        case (instr.r_fmt.opcode)
            op_special: begin
                case (instr.r_fmt.funct)
                    fn_addu, fn_subu: kind = alu_r;
                    fn_jr:            kind = jump_reg;
                    fn_syscall:       kind = syscall;
                    default:          kind = other;
                endcase
            end
            op_ori, op_lui: kind = alu_i;
            op_lw:          kind = load;
            op_sw:          kind = store;
            op_beq:         kind = branch_eq;
            op_j:           kind = jump;
            op_jal:         kind = jump_link;
            default:        kind = other;
        endcase
    end

    // register fields and usage
    always_comb begin
        rs       = instr.i_fmt.rs;
        rt       = instr.i_fmt.rt;
        imm16    = instr.i_fmt.imm16;
        target26 = instr.j_fmt.target26;
        rs_used  = 1'b0;
        rt_used  = 1'b0;
        dest_lr  = 5'd0;
        case (kind)
            alu_r: begin
                rs_used = 1'b1;
                rt_used = 1'b1;
                dest_lr = instr.r_fmt.rd;
            end
            alu_i: begin
                // lui has no source
                rs_used = (instr.i_fmt.opcode != op_lui);
                dest_lr = instr.i_fmt.rt;
            end
            load: begin
                rs_used = 1'b1;
                dest_lr = instr.i_fmt.rt;
            end
            store, branch_eq: begin
                rs_used = 1'b1;
                rt_used = 1'b1;
            end
            jump_reg:  rs_used = 1'b1;
            jump_link: dest_lr = 5'd31;
            default:   dest_lr = 5'd0;
        endcase
        // writes to r0 are dropped
        has_dest = (dest_lr != 5'd0);
    end

endmodule

// ==== source/issue_pkg.sv ====
package issue_pkg;

    // ========================================================================
    // sizes
    // ========================================================================
    localparam int num_lanes    = 2;
    localparam int num_phy_regs = 48;
    localparam int num_log_regs = 32;
    localparam int phy_idx_w    = 6;
    localparam int id_width     = 8;

    localparam logic [31:0] reset_pc = 32'h0000_3000;

    typedef logic [phy_idx_w-1:0] phy_idx_t;
    typedef logic [id_width-1:0]  issue_id_t;

    // ========================================================================
    // instruction encodings
    // ========================================================================
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct field under op_special
    localparam logic [5:0] fn_addu    = 6'h21;
    localparam logic [5:0] fn_subu    = 6'h23;
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_syscall = 6'h0c;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } j_fmt_t;

    // one fetched word, three views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // ten kinds, so four bits
    typedef enum logic [3:0] {
        alu_r,
        alu_i,
        load,
        store,
        branch_eq,
        jump,
        jump_link,
        jump_reg,
        syscall,
        other
    } instr_kind_e;

endpackage

// ==== source/issue_sequencer.sv ====
`timescale 1ns/1ps

module issue_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req            [issue_pkg::num_lanes],
    input  issue_pkg::instr_kind_e kind           [issue_pkg::num_lanes],
    input  logic [25:0]            target26       [issue_pkg::num_lanes],
    input  logic                   slot_grant     [issue_pkg::num_lanes],
    input  issue_pkg::phy_idx_t    phy_rs         [issue_pkg::num_lanes],
    input  issue_pkg::phy_idx_t    phy_rt         [issue_pkg::num_lanes],
    input  issue_pkg::phy_idx_t    phy_dst        [issue_pkg::num_lanes],
    input  logic                   redirect_valid [issue_pkg::num_lanes],
    input  issue_pkg::issue_id_t   redirect_id    [issue_pkg::num_lanes],
    input  logic [31:0]            redirect_pc    [issue_pkg::num_lanes],
    output logic                   slot_live      [issue_pkg::num_lanes],
    output logic [31:0]            imem_addr,
    output logic                   pkt_valid      [issue_pkg::num_lanes],
    output logic [31:0]            pkt_pc         [issue_pkg::num_lanes],
    output issue_pkg::issue_id_t   pkt_issue_id   [issue_pkg::num_lanes],
    output issue_pkg::phy_idx_t    pkt_phy_rs     [issue_pkg::num_lanes],
    output issue_pkg::phy_idx_t    pkt_phy_rt     [issue_pkg::num_lanes],
    output issue_pkg::phy_idx_t    pkt_phy_dst    [issue_pkg::num_lanes],
    output logic [31:0]            pkt_next_pc    [issue_pkg::num_lanes],
    output logic                   rf_alloc_wen   [issue_pkg::num_lanes],
    output issue_pkg::phy_idx_t    rf_alloc_pr    [issue_pkg::num_lanes]
);

    import issue_pkg::*;

    logic [31:0] pc;
    issue_id_t   id_base;
    logic        jr_wait;
    issue_id_t   jr_id;

    int          lane_slot [num_lanes];
    int          num_req;
    int          num_grant;
    logic        stop;
    logic [31:0] slot_pc   [num_lanes];
    logic [31:0] slot_next [num_lanes];
    logic        jump_seen;
    logic [31:0] jump_pc;
    logic        jr_seen;
    issue_id_t   jr_seen_id;
    logic        redir_hit;
    logic [31:0] redir_pc;

    assign imem_addr = pc;

    // ========================================================================
    // lane to slot mapping and liveness
    // ========================================================================
    always_comb begin
        num_req = 0;
        for (int l = 0; l < num_lanes; l++) begin
            lane_slot[l] = num_req;
            num_req      = num_req + int'(req[l]);
        end
        // a jump of any sort ends the group
        stop = jr_wait;
        for (int s = 0; s < num_lanes; s++) begin
            slot_live[s] = !stop && (s < num_req);
            if (kind[s] == jump || kind[s] == jump_link || kind[s] == jump_reg) begin
                stop = 1'b1;
            end
        end
    end

    // slot pcs, predicted next pc, summary of granted slots
    always_comb begin
        num_grant  = 0;
        jump_seen  = 1'b0;
        jump_pc    = '0;
        jr_seen    = 1'b0;
        jr_seen_id = '0;
        for (int s = 0; s < num_lanes; s++) begin
            slot_pc[s] = pc + 32'(4 * s);
            case (kind[s])
                jump, jump_link: slot_next[s] = {slot_pc[s][31:28], target26[s], 2'b00};
                jump_reg:        slot_next[s] = '0;
                default:         slot_next[s] = slot_pc[s] + 32'd4;
            endcase
            if (slot_grant[s]) begin
                num_grant = num_grant + 1;
                if (kind[s] == jump || kind[s] == jump_link) begin
                    jump_seen = 1'b1;
                    jump_pc   = slot_next[s];
                end
                if (kind[s] == jump_reg) begin
                    jr_seen    = 1'b1;
                    jr_seen_id = id_base + issue_id_t'(s);
                end
            end
        end

        // redirect that resolves the pending jr
        redir_hit = 1'b0;
        redir_pc  = '0;
        for (int l = 0; l < num_lanes; l++) begin
            if (redirect_valid[l] && redirect_id[l] == jr_id) begin
                redir_hit = 1'b1;
                redir_pc  = redirect_pc[l];
            end
        end
    end

    // ========================================================================
    // fetch pc, issue id, jr wait and output packets
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= reset_pc;
            id_base <= '0;
            jr_wait <= 1'b0;
            for (int l = 0; l < num_lanes; l++) begin
                pkt_valid[l]    <= 1'b0;
                pkt_pc[l]       <= '0;
                pkt_issue_id[l] <= '0;
                pkt_phy_rs[l]   <= '0;
                pkt_phy_rt[l]   <= '0;
                pkt_phy_dst[l]  <= '0;
                pkt_next_pc[l]  <= '0;
                rf_alloc_wen[l] <= 1'b0;
                rf_alloc_pr[l]  <= '0;
            end
        end else begin
            if (jr_wait) begin
                if (redir_hit) begin
                    pc      <= redir_pc;
                    jr_wait <= 1'b0;
                end
            end else if (jump_seen) begin
                pc <= jump_pc;
            end else begin
                pc <= pc + 32'(4 * num_grant);
            end
            if (jr_seen) begin
                jr_wait <= 1'b1;
            end
            id_base <= id_base + issue_id_t'(num_grant);

            for (int l = 0; l < num_lanes; l++) begin
                if (req[l] && slot_grant[lane_slot[l]]) begin
                    pkt_valid[l]    <= 1'b1;
                    pkt_pc[l]       <= slot_pc[lane_slot[l]];
                    pkt_issue_id[l] <= id_base + issue_id_t'(lane_slot[l]);
                    pkt_phy_rs[l]   <= phy_rs[lane_slot[l]];
                    pkt_phy_rt[l]   <= phy_rt[lane_slot[l]];
                    pkt_phy_dst[l]  <= phy_dst[lane_slot[l]];
                    pkt_next_pc[l]  <= slot_next[lane_slot[l]];
                    // only allocated registers are nonzero
                    rf_alloc_wen[l] <= (phy_dst[lane_slot[l]] != '0);
                    rf_alloc_pr[l]  <= phy_dst[lane_slot[l]];
                end else begin
                    pkt_valid[l]    <= 1'b0;
                    pkt_pc[l]       <= '0;
                    pkt_issue_id[l] <= '0;
                    pkt_phy_rs[l]   <= '0;
                    pkt_phy_rt[l]   <= '0;
                    pkt_phy_dst[l]  <= '0;
                    pkt_next_pc[l]  <= '0;
                    rf_alloc_wen[l] <= 1'b0;
                    rf_alloc_pr[l]  <= '0;
                end
            end
        end
    end

    // id of the jr being waited on
    always_ff @(posedge clk) begin
        if (jr_seen) begin
            jr_id <= jr_seen_id;
        end
    end

endmodule

// ==== source/issue_top.sv ====
`timescale 1ns/1ps

module issue_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req            [issue_pkg::num_lanes],
    input  logic [31:0]          imem_data      [issue_pkg::num_lanes],
    input  logic                 redirect_valid [issue_pkg::num_lanes],
    input  issue_pkg::issue_id_t redirect_id    [issue_pkg::num_lanes],
    input  logic [31:0]          redirect_pc    [issue_pkg::num_lanes],
    output logic [31:0]          imem_addr,
    output logic                 pkt_valid      [issue_pkg::num_lanes],
    output logic [31:0]          pkt_pc         [issue_pkg::num_lanes],
    output issue_pkg::issue_id_t pkt_issue_id   [issue_pkg::num_lanes],
    output issue_pkg::phy_idx_t  pkt_phy_rs     [issue_pkg::num_lanes],
    output issue_pkg::phy_idx_t  pkt_phy_rt     [issue_pkg::num_lanes],
    output issue_pkg::phy_idx_t  pkt_phy_dst    [issue_pkg::num_lanes],
    output logic [31:0]          pkt_next_pc    [issue_pkg::num_lanes],
    output logic                 rf_alloc_wen   [issue_pkg::num_lanes],
    output issue_pkg::phy_idx_t  rf_alloc_pr    [issue_pkg::num_lanes]
);

    import issue_pkg::*;

    // per-slot decode results
    instr_kind_e kind     [num_lanes];
    logic [4:0]  rs       [num_lanes];
    logic [4:0]  rt       [num_lanes];
    logic        rs_used  [num_lanes];
    logic        rt_used  [num_lanes];
    logic [4:0]  dest_lr  [num_lanes];
    logic        has_dest [num_lanes];
    logic [25:0] target26 [num_lanes];

    // rename handshake
    logic        slot_live  [num_lanes];
    logic        slot_grant [num_lanes];
    phy_idx_t    phy_rs     [num_lanes];
    phy_idx_t    phy_rt     [num_lanes];
    phy_idx_t    phy_dst    [num_lanes];

    for (genvar k = 0; k < num_lanes; k++) begin : g_dec
        instr_decoder dec_i (
            .instr    (imem_data[k]),
            .kind     (kind[k]),
            .rs       (rs[k]),
            .rt       (rt[k]),
            .rs_used  (rs_used[k]),
            .rt_used  (rt_used[k]),
            .dest_lr  (dest_lr[k]),
            .has_dest (has_dest[k]),
            .imm16    (),
            .target26 (target26[k])
        );
    end

    rename_unit rename_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .slot_live  (slot_live),
        .rs         (rs),
        .rt         (rt),
        .rs_used    (rs_used),
        .rt_used    (rt_used),
        .dest_lr    (dest_lr),
        .has_dest   (has_dest),
        .slot_grant (slot_grant),
        .phy_rs     (phy_rs),
        .phy_rt     (phy_rt),
        .phy_dst    (phy_dst)
    );

    issue_sequencer seq_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req),
        .kind           (kind),
        .target26       (target26),
        .slot_grant     (slot_grant),
        .phy_rs         (phy_rs),
        .phy_rt         (phy_rt),
        .phy_dst        (phy_dst),
        .redirect_valid (redirect_valid),
        .redirect_id    (redirect_id),
        .redirect_pc    (redirect_pc),
        .slot_live      (slot_live),
        .imem_addr      (imem_addr),
        .pkt_valid      (pkt_valid),
        .pkt_pc         (pkt_pc),
        .pkt_issue_id   (pkt_issue_id),
        .pkt_phy_rs     (pkt_phy_rs),
        .pkt_phy_rt     (pkt_phy_rt),
        .pkt_phy_dst    (pkt_phy_dst),
        .pkt_next_pc    (pkt_next_pc),
        .rf_alloc_wen   (rf_alloc_wen),
        .rf_alloc_pr    (rf_alloc_pr)
    );

endmodule

// ==== source/rename_unit.sv ====
`timescale 1ns/1ps

module rename_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req        [issue_pkg::num_lanes],
    input  logic                slot_live  [issue_pkg::num_lanes],
    input  logic [4:0]          rs         [issue_pkg::num_lanes],
    input  logic [4:0]          rt         [issue_pkg::num_lanes],
    input  logic                rs_used    [issue_pkg::num_lanes],
    input  logic                rt_used    [issue_pkg::num_lanes],
    input  logic [4:0]          dest_lr    [issue_pkg::num_lanes],
    input  logic                has_dest   [issue_pkg::num_lanes],
    output logic                slot_grant [issue_pkg::num_lanes],
    output issue_pkg::phy_idx_t phy_rs     [issue_pkg::num_lanes],
    output issue_pkg::phy_idx_t phy_rt     [issue_pkg::num_lanes],
    output issue_pkg::phy_idx_t phy_dst    [issue_pkg::num_lanes]
);

    import issue_pkg::*;

    // alias table, free bitmap, reclaim set
    phy_idx_t                rat      [num_log_regs];
    logic [num_phy_regs-1:0] free_map;
    logic [num_phy_regs-1:0] reclaim_map;

    // per-cycle working copies
    phy_idx_t                rat_work [num_log_regs];
    logic [num_phy_regs-1:0] free_work;
    logic [num_phy_regs-1:0] reclaim_work;

    logic                    quiet;
    logic                    chain_ok;
    logic                    found;
    phy_idx_t                alloc_pr;
    phy_idx_t                old_pr;

    // ========================================================================
    // in-order rename walk over the slots
    // ========================================================================
    always_comb begin
        quiet = 1'b1;
        for (int l = 0; l < num_lanes; l++) begin
            quiet = quiet & req[l];
        end

        free_work    = free_map;
        reclaim_work = reclaim_map;
        rat_work     = rat;
        chain_ok     = 1'b1;
        found        = 1'b0;
        alloc_pr     = '0;
        old_pr       = '0;

        // every lane asking means nothing is in flight
        if (quiet) begin
            free_work    = free_work | reclaim_work;
            reclaim_work = '0;
        end

        for (int s = 0; s < num_lanes; s++) begin
            // sources see mappings from earlier slots
            phy_rs[s]  = rs_used[s] ? rat_work[rs[s]] : '0;
            phy_rt[s]  = rt_used[s] ? rat_work[rt[s]] : '0;
            phy_dst[s] = '0;

            // lowest free register, 32 and up
            found    = 1'b0;
            alloc_pr = '0;
            for (int p = num_phy_regs - 1; p >= num_log_regs; p--) begin
                if (free_work[p]) begin
                    found    = 1'b1;
                    alloc_pr = phy_idx_t'(p);
                end
            end

            slot_grant[s] = chain_ok && slot_live[s] && (found || !has_dest[s]);
            chain_ok      = slot_grant[s];

            if (slot_grant[s] && has_dest[s]) begin
                old_pr = rat_work[dest_lr[s]];
                // initial mappings are never recycled
                if (old_pr >= phy_idx_t'(num_log_regs)) begin
                    reclaim_work[old_pr] = 1'b1;
                end
                free_work[alloc_pr]  = 1'b0;
                rat_work[dest_lr[s]] = alloc_pr;
                phy_dst[s]           = alloc_pr;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < num_log_regs; r++) begin
                rat[r] <= phy_idx_t'(r);
            end
            free_map    <= {{(num_phy_regs - num_log_regs){1'b1}}, {num_log_regs{1'b0}}};
            reclaim_map <= '0;
        end else begin
            rat         <= rat_work;
            free_map    <= free_work;
            reclaim_map <= reclaim_work;
        end
    end

endmodule
